/* verilog/sched_pkg.sv */
package sched_pkg;

    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int NUM_BARRIERS = 2;
    localparam int PC_BITS      = 32;
    localparam int INSTR_BYTES  = 4;

    typedef logic [1:0]             wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [NUM_WARPS-1:0]   wmask_t;
    typedef logic [PC_BITS-1:0]     pc_t;
    typedef logic [0:0]             bar_id_t;

    // one warp handed to fetch, 38 bits
    typedef struct packed {
        wid_t   wid;
        tmask_t tmask;
        pc_t    pc;
    } sched_item_t;

    typedef enum logic [1:0] {
        TMC,
        WSPAWN,
        BARRIER
    } wctl_op_t;

    // argument word shared by all warp-control ops
    localparam int WCTL_ARG_BITS = 38;

    typedef struct packed {
        logic [WCTL_ARG_BITS-NUM_THREADS-1:0] pad;
        tmask_t                               tmask;
    } tmc_arg_t;

    typedef struct packed {
        logic [WCTL_ARG_BITS-NUM_WARPS-PC_BITS-1:0] pad;
        wmask_t                                     wmask;
        pc_t                                        pc;
    } wspawn_arg_t;

    typedef struct packed {
        logic [WCTL_ARG_BITS-$bits(bar_id_t)-$bits(wid_t)-1:0] pad;
        bar_id_t                                               id;
        wid_t                                                  size_m1;
    } bar_arg_t;

    // decoded according to the op field
    typedef union packed {
        tmc_arg_t    tmc;
        wspawn_arg_t wspawn;
        bar_arg_t    barrier;
    } wctl_arg_u;

    typedef struct packed {
        logic      valid;
        wid_t      wid;
        wctl_op_t  op;
        wctl_arg_u arg;
    } wctl_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
        logic taken;
        pc_t  dest;
    } branch_t;

    typedef struct packed {
        logic valid;
        wid_t wid;
    } unlock_t;

endpackage

/* verilog/warp_select.sv */
`timescale 1ns/1ps

module warp_select import sched_pkg::*; (
    input  wmask_t                 ready_warps,
    input  tmask_t [NUM_WARPS-1:0] tmasks,
    input  pc_t    [NUM_WARPS-1:0] pcs,
    output logic                   pick_valid,
    output sched_item_t            pick_item
);

    wid_t sel_wid;

    // lowest index wins, so scan from the top down
    always_comb begin
        sel_wid = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_wid = wid_t'(i);
            end
        end
    end

    assign pick_valid = |ready_warps;

    always_comb begin
        pick_item.wid   = sel_wid;
        pick_item.tmask = tmasks[sel_wid];
        pick_item.pc    = pcs[sel_wid];
    end

endmodule

/* verilog/barrier_unit.sv */
`timescale 1ns/1ps

module barrier_unit import sched_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  wctl_t  wctl,
    input  wmask_t active,
    output logic   release_valid,
    output wmask_t release_mask
);

    wmask_t [NUM_BARRIERS-1:0] bar_masks;
    wid_t   [NUM_BARRIERS-1:0] bar_ctrs;

    logic    arrive;
    logic    last_arrival;
    bar_id_t bar_id;
    wmask_t  arrive_mask;
    wmask_t  waiting_any;

    assign arrive = wctl.valid && (wctl.op == BARRIER);
    assign bar_id = wctl.arg.barrier.id;

    // waiting set including the warp arriving now
    assign arrive_mask  = bar_masks[bar_id] | (wmask_t'(1) << wctl.wid);
    assign last_arrival = arrive && (bar_ctrs[bar_id] == wctl.arg.barrier.size_m1);

    assign release_valid = last_arrival;
    assign release_mask  = last_arrival ? arrive_mask : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_masks <= '0;
            bar_ctrs  <= '0;
        end else if (arrive) begin
            if (last_arrival) begin
                bar_masks[bar_id] <= '0;
                bar_ctrs[bar_id]  <= '0;
            end else begin
                bar_masks[bar_id] <= arrive_mask;
                bar_ctrs[bar_id]  <= bar_ctrs[bar_id] + 1'b1;
            end
        end
    end

    always_comb begin
        waiting_any = '0;
        for (int b = 0; b < NUM_BARRIERS; b++) begin
            waiting_any = waiting_any | bar_masks[b];
        end
    end

    // a warp parked at a barrier must not be retired under it
    a_waiters_active: assert property (
        @(posedge clk) disable iff (reset) (waiting_any & ~active) == '0
    );

endmodule

/* verilog/warp_state.sv */
`timescale 1ns/1ps

module warp_state import sched_pkg::*; #(
    parameter pc_t STARTUP_PC = 32'h8000_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  wctl_t                  wctl,
    input  branch_t                branch,
    input  unlock_t                unlock,
    input  logic                   release_valid,
    input  wmask_t                 release_mask,
    input  logic                   fire,
    input  wid_t                   fire_wid,
    output wmask_t                 ready_warps,
    output wmask_t                 active,
    output tmask_t [NUM_WARPS-1:0] tmasks,
    output pc_t    [NUM_WARPS-1:0] pcs,
    output logic                   busy
);

    wmask_t                 active_q, active_n;
    wmask_t                 stalled_q, stalled_n;
    tmask_t [NUM_WARPS-1:0] tmasks_q, tmasks_n;
    pc_t    [NUM_WARPS-1:0] pcs_q, pcs_n;

    // spawn waits here until only the spawning warp is left
    logic   spawn_valid;
    wmask_t spawn_wmask;
    pc_t    spawn_pc;
    wid_t   spawn_wid;

    logic single_warp;
    logic spawn_go;

    assign single_warp = (active_q != '0) && ((active_q & (active_q - 1'b1)) == '0);
    assign spawn_go    = spawn_valid && single_warp;

    always_comb begin
        active_n  = active_q;
        stalled_n = stalled_q;
        tmasks_n  = tmasks_q;
        pcs_n     = pcs_q;

        // later updates win over earlier ones
        if (unlock.valid) begin
            stalled_n[unlock.wid] = 1'b0;
        end

        if (spawn_go) begin
            active_n  = active_n | spawn_wmask;
            stalled_n = stalled_n & ~spawn_wmask;
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (spawn_wmask[i]) begin
                    tmasks_n[i] = tmask_t'(1);
                    pcs_n[i]    = spawn_pc;
                end
            end
            stalled_n[spawn_wid] = 1'b0;
        end

        if (wctl.valid && wctl.op == TMC) begin
            // an empty mask retires the warp
            active_n[wctl.wid]  = (wctl.arg.tmc.tmask != '0);
            tmasks_n[wctl.wid]  = wctl.arg.tmc.tmask;
            stalled_n[wctl.wid] = 1'b0;
        end

        if (release_valid) begin
            stalled_n = stalled_n & ~release_mask;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                pcs_n[branch.wid] = branch.dest;
            end
            stalled_n[branch.wid] = 1'b0;
        end

        // stall until decode says otherwise
        if (fire) begin
            stalled_n[fire_wid] = 1'b1;
            pcs_n[fire_wid]     = pcs_q[fire_wid] + pc_t'(INSTR_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q    <= wmask_t'(1);
            stalled_q   <= '0;
            tmasks_q    <= '0;
            tmasks_q[0] <= tmask_t'(1);
            pcs_q       <= '0;
            pcs_q[0]    <= STARTUP_PC;
            spawn_valid <= 1'b0;
        end else begin
            active_q  <= active_n;
            stalled_q <= stalled_n;
            tmasks_q  <= tmasks_n;
            pcs_q     <= pcs_n;
            if (spawn_go) begin
                spawn_valid <= 1'b0;
            end
            if (wctl.valid && wctl.op == WSPAWN) begin
                spawn_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wctl.valid && wctl.op == WSPAWN) begin
            spawn_wmask <= wctl.arg.wspawn.wmask;
            spawn_pc    <= wctl.arg.wspawn.pc;
            spawn_wid   <= wctl.wid;
        end
    end

    assign ready_warps = active_q & ~stalled_q;
    assign active      = active_q;
    assign tmasks      = tmasks_q;
    assign pcs         = pcs_q;
    assign busy        = |active_q;

    // fire comes back through selection and the buffer handshake
    a_fire_ready: assert property (
        @(posedge clk) disable iff (reset) fire |-> ready_warps[fire_wid]
    );

endmodule

/* verilog/sched_out_buf.sv */
`timescale 1ns/1ps

module sched_out_buf import sched_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  sched_item_t in_item,
    output logic        out_valid,
    input  logic        out_ready,
    output sched_item_t out_item
);

    // output register plus one skid entry
    logic        out_valid_q;
    logic        skid_valid_q;
    sched_item_t out_item_q;
    sched_item_t skid_item_q;

    logic out_free;

    assign out_free = out_ready || !out_valid_q;
    assign in_ready = !skid_valid_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q  <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (out_free) begin
            out_valid_q  <= skid_valid_q || in_valid;
            skid_valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_item_q <= skid_valid_q ? skid_item_q : in_item;
        end else if (in_valid && in_ready) begin
            skid_item_q <= in_item;
        end
    end

    assign out_valid = out_valid_q;
    assign out_item  = out_item_q;

    a_out_stable: assert property (
        @(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_item)
    );

    // skid only fills behind a held output
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset) skid_valid_q |-> out_valid_q
    );

endmodule

/* verilog/warp_sched_top.sv */
`timescale 1ns/1ps

module warp_sched_top import sched_pkg::*; #(
    parameter pc_t STARTUP_PC = 32'h8000_0000
) (
    input  logic        clk,
    input  logic        reset,
    input  wctl_t       wctl,
    input  branch_t     branch,
    input  unlock_t     unlock,
    input  logic        out_ready,
    output logic        out_valid,
    output sched_item_t out_item,
    output logic        busy
);

    wmask_t                  ready_warps;
    wmask_t                  active;
    wmask_t                  release_mask;
    logic                    release_valid;
    tmask_t [NUM_WARPS-1:0]  tmasks;
    pc_t    [NUM_WARPS-1:0]  pcs;

    logic        pick_valid;
    logic        pick_ready;
    sched_item_t pick_item;

    // a warp leaves selection only when the buffer takes it
    wire fire = pick_valid && pick_ready;

    warp_state #(
        .STARTUP_PC (STARTUP_PC)
    ) state_i (
        .clk           (clk),
        .reset         (reset),
        .wctl          (wctl),
        .branch        (branch),
        .unlock        (unlock),
        .release_valid (release_valid),
        .release_mask  (release_mask),
        .fire          (fire),
        .fire_wid      (pick_item.wid),
        .ready_warps   (ready_warps),
        .active        (active),
        .tmasks        (tmasks),
        .pcs           (pcs),
        .busy          (busy)
    );

    barrier_unit barrier_i (
        .clk           (clk),
        .reset         (reset),
        .wctl          (wctl),
        .active        (active),
        .release_valid (release_valid),
        .release_mask  (release_mask)
    );

    warp_select select_i (
        .ready_warps (ready_warps),
        .tmasks      (tmasks),
        .pcs         (pcs),
        .pick_valid  (pick_valid),
        .pick_item   (pick_item)
    );

    sched_out_buf out_buf_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (pick_valid),
        .in_ready  (pick_ready),
        .in_item   (pick_item),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_item  (out_item)
    );

endmodule

/* test/tb_warp_sched.sv */
`timescale 1ns/1ps

module tb_warp_sched import sched_pkg::*; ();

    localparam pc_t START_PC = 32'h8000_0000;
    localparam int  TIMEOUT  = 3000;

    logic        clk;
    logic        reset;
    wctl_t       wctl;
    branch_t     branch;
    unlock_t     unlock;
    logic        out_ready;
    logic        out_valid;
    sched_item_t out_item;
    logic        busy;

    // items taken by the fetch side, in arrival order
    sched_item_t got_q[$];
    pc_t         exp_pc[NUM_WARPS];
    tmask_t      exp_tmask[NUM_WARPS];
    integer      seed = 32'h315a;
    int          cycle_count = 0;

    warp_sched_top #(
        .STARTUP_PC (START_PC)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .wctl      (wctl),
        .branch    (branch),
        .unlock    (unlock),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .out_item  (out_item),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // mid-cycle sample, the transfer itself happens on the next rising edge
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            got_q.push_back(out_item);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_item(sched_item_t got, sched_item_t exp, string name);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_wmask_busy(logic got, logic exp, string name);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%b expected=%b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_wid(wid_t got, wid_t exp, string name);
        if (got !== exp) begin
            $display("FAIL time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic sched_item_t make_item(wid_t w, tmask_t m, pc_t pc);
        sched_item_t item;
        item.wid   = w;
        item.tmask = m;
        item.pc    = pc;
        return item;
    endfunction

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_item(output sched_item_t item, input string what);
        int n;
        n = 0;
        while (got_q.size() == 0) begin
            if (n == 40) begin
                $display("no item arrived for %s", what);
                stop_run();
            end
            idle(1);
            n++;
        end
        item = got_q.pop_front();
    endtask

    // next item must be warp w at its tracked pc and mask
    task automatic expect_warp(wid_t w, string what);
        sched_item_t item;
        wait_item(item, what);
        check_wid(item.wid, w, "out_item.wid");
        check_item(item, make_item(w, exp_tmask[w], exp_pc[w]), "out_item");
        exp_pc[w] = exp_pc[w] + pc_t'(INSTR_BYTES);
    endtask

    task automatic expect_quiet(int n, string what);
        idle(n);
        if (got_q.size() != 0) begin
            $display("unexpected item from warp %0d %s", got_q[0].wid, what);
            stop_run();
        end
    endtask

    task automatic pulse_event(wctl_t c, branch_t b, unlock_t u);
        wctl   = c;
        branch = b;
        unlock = u;
        idle(1);
        wctl   = '0;
        branch = '0;
        unlock = '0;
    endtask

    task automatic send_unlock(wid_t w);
        unlock_t u;
        u.valid = 1'b1;
        u.wid   = w;
        pulse_event('0, '0, u);
    endtask

    task automatic send_branch(wid_t w, logic taken, pc_t dest);
        branch_t b;
        b.valid = 1'b1;
        b.wid   = w;
        b.taken = taken;
        b.dest  = dest;
        pulse_event('0, b, '0);
    endtask

    task automatic send_wctl(wid_t w, wctl_op_t op, wctl_arg_u arg);
        wctl_t c;
        c.valid = 1'b1;
        c.wid   = w;
        c.op    = op;
        c.arg   = arg;
        pulse_event(c, '0, '0);
    endtask

    task automatic reset_and_rearm();
        expect_warp(0, "first item after reset");
        expect_quiet(10, "while warp 0 is stalled");
        send_unlock(0);
        expect_warp(0, "warp 0 after unlock");
    endtask

    task automatic branch_redirect();
        pc_t dest;
        dest = pc_t'($random(seed)) & ~pc_t'(3);
        send_branch(0, 1'b1, dest);
        exp_pc[0] = dest;
        expect_warp(0, "warp 0 after taken branch");
        send_branch(0, 1'b0, pc_t'($random(seed)));
        expect_warp(0, "warp 0 after not-taken branch");
    endtask

    task automatic spawn_order();
        wctl_arg_u arg;
        pc_t       spawn_pc;
        spawn_pc = pc_t'($random(seed)) & ~pc_t'(3);
        arg = '0;
        arg.wspawn.wmask = 4'b1110;
        arg.wspawn.pc    = spawn_pc;
        send_wctl(0, WSPAWN, arg);
        for (int w = 1; w < NUM_WARPS; w++) begin
            exp_pc[w]    = spawn_pc;
            exp_tmask[w] = tmask_t'(1);
        end
        // the spawning warp is released too and wins the first slot
        for (int w = 0; w < NUM_WARPS; w++) begin
            expect_warp(wid_t'(w), "spawned warps in wid order");
        end
    endtask

    task automatic local_barrier();
        wctl_arg_u arg;
        arg = '0;
        arg.barrier.id      = 1'b0;
        arg.barrier.size_m1 = 2'd1;
        send_wctl(1, BARRIER, arg);
        expect_quiet(8, "while warp 1 waits at barrier 0");
        send_wctl(2, BARRIER, arg);
        expect_warp(1, "warp 1 after barrier release");
        expect_warp(2, "warp 2 after barrier release");
    endtask

    task automatic back_pressure();
        sched_item_t held;
        out_ready = 1'b0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            send_unlock(wid_t'(w));
        end
        @(negedge clk);
        check_wmask_busy(out_valid, 1'b1, "out_valid");
        held = out_item;
        check_item(held, make_item(0, exp_tmask[0], exp_pc[0]), "out_item");
        repeat (6) begin
            @(negedge clk);
            check_wmask_busy(out_valid, 1'b1, "out_valid");
            check_item(out_item, held, "out_item");
        end
        @(posedge clk);
        #1;
        out_ready = 1'b1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            expect_warp(wid_t'(w), "items after back-pressure");
        end
        expect_quiet(10, "after the buffer drained");
    endtask

    task automatic thread_mask_ctl();
        wctl_arg_u arg;
        arg = '0;
        arg.tmc.tmask = 4'b1010;
        send_wctl(3, TMC, arg);
        exp_tmask[3] = 4'b1010;
        expect_warp(3, "warp 3 after TMC");
        check_wmask_busy(busy, 1'b1, "busy");
        arg.tmc.tmask = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            send_wctl(wid_t'(w), TMC, arg);
        end
        idle(1);
        check_wmask_busy(busy, 1'b0, "busy");
        expect_quiet(10, "after all warps were retired");
    endtask

    initial begin
        reset     = 1'b1;
        wctl      = '0;
        branch    = '0;
        unlock    = '0;
        out_ready = 1'b1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            exp_pc[w]    = '0;
            exp_tmask[w] = '0;
        end
        exp_pc[0]    = START_PC;
        exp_tmask[0] = tmask_t'(1);
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_and_rearm();
        branch_redirect();
        spawn_order();
        local_barrier();
        back_pressure();
        thread_mask_ctl();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* tb.f */
verilog/sched_pkg.sv
verilog/warp_select.sv
verilog/barrier_unit.sv
verilog/warp_state.sv
verilog/sched_out_buf.sv
verilog/warp_sched_top.sv
test/tb_warp_sched.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_warp_sched
FILELIST = tb.f
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), check $(LOG) for the pass message"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
